// ==== logic/board_pkg.sv ====
`default_nettype none

package board_pkg;

    // byte address on the top-level bus
    typedef logic [11:0] addr_t;

    // one data word and its byte lanes
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // word inside one bank, taken from addr[9:2]
    typedef logic [7:0] word_idx_t;

    // lowest address bit of the word index
    localparam int unsigned WORD_LSB = 2;

    // 0 selects the data RAM, 1 selects the instruction ROM
    localparam int unsigned BANK_SEL_BIT = 11;

    // bits per byte lane
    localparam int unsigned LANE_BITS = 8;

endpackage

`default_nettype wire

// ==== logic/mem_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one word-wide memory port between the bridge and a bank
interface mem_port_if;

    logic                  req;
    logic                  we;
    board_pkg::strb_t      be;
    board_pkg::word_idx_t  idx;
    board_pkg::data_t      wdata;
    board_pkg::data_t      rdata;

    modport host (
        output req, we, be, idx, wdata,
        input  rdata
    );

    modport bank (
        input  req, we, be, idx, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// ==== logic/reset_stretch.sv ====
`timescale 1ns/1ps
`default_nettype none

module reset_stretch #(
    parameter int unsigned RST_CYCLES = 16
) (
    input  wire logic clk,
    input  wire logic rstn,
    output logic      ready
);

    // one spare count so RST_CYCLES itself always fits
    localparam int unsigned CNT_W = $clog2(RST_CYCLES + 1);

    logic [CNT_W-1:0] count;

    // ready rises on the RST_CYCLES-th edge that samples rstn high
    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            if (count == CNT_W'(RST_CYCLES - 1)) begin
                ready <= 1'b1;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/byte_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_ram #(
    parameter int unsigned RAM_WORDS = 256
) (
    input  wire logic  clk,
    input  wire logic  rstn,
    mem_port_if.bank   port
);

    localparam int unsigned AW    = $clog2(RAM_WORDS);
    localparam int unsigned LANES = $bits(board_pkg::strb_t);

    board_pkg::data_t mem [RAM_WORDS];
    logic [AW-1:0]    addr;

    // index wraps when the bank is smaller than the index range
    assign addr = port.idx[AW-1:0];

    // byte-merge write, untouched lanes keep their old value
    always_ff @(posedge clk) begin
        if (port.req && port.we) begin
            for (int b = 0; b < LANES; b++) begin
                if (port.be[b]) begin
                    mem[addr][b*board_pkg::LANE_BITS +: board_pkg::LANE_BITS] <=
                        port.wdata[b*board_pkg::LANE_BITS +: board_pkg::LANE_BITS];
                end
            end
        end
    end

    // registered read, held until the next accepted read
    always_ff @(posedge clk) begin
        if (!rstn) begin
            port.rdata <= '0;
        end else if (port.req && !port.we) begin
            port.rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/instr_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_rom #(
    parameter int unsigned ROM_WORDS = 256
) (
    input  wire logic  clk,
    input  wire logic  rstn,
    mem_port_if.bank   port
);

    localparam int unsigned AW    = $clog2(ROM_WORDS);
    localparam int unsigned LANES = $bits(board_pkg::strb_t);

    // byte b of word i holds (i + b) mod 256
    function automatic board_pkg::data_t rom_word(input int unsigned i);
        board_pkg::data_t w;
        for (int unsigned b = 0; b < LANES; b++) begin
            w[b*board_pkg::LANE_BITS +: board_pkg::LANE_BITS] = 8'((i + b) % 256);
        end
        return w;
    endfunction

    board_pkg::data_t rom [ROM_WORDS];
    logic [AW-1:0]    addr;

    for (genvar i = 0; i < ROM_WORDS; i++) begin : g_table
        assign rom[i] = rom_word(i);
    end

    assign addr = port.idx[AW-1:0];

    // writes never change the contents or the output register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            port.rdata <= '0;
        end else if (port.req && !port.we) begin
            port.rdata <= rom[addr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/mem_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_bridge (
    input  wire logic              clk,
    input  wire logic              rstn,
    input  wire logic              ready,

    input  wire logic              req,
    input  wire logic              we,
    input  wire board_pkg::addr_t  addr,
    input  wire board_pkg::strb_t  be,
    input  wire board_pkg::data_t  wdata,

    output logic                   ack,
    output board_pkg::data_t       rdata,

    mem_port_if.host               ram,
    mem_port_if.host               rom
);

    localparam int unsigned IDX_W = $bits(board_pkg::word_idx_t);

    logic                  accept;
    logic                  sel_rom;
    board_pkg::word_idx_t  idx;

    // bank selected by the request that is being acknowledged
    logic                  sel_rom_q;
    logic                  ack_q;

    // requests before the stretcher releases are dropped
    assign accept  = req && ready;
    assign sel_rom = addr[board_pkg::BANK_SEL_BIT];

    // bit 10 and bits 1:0 are not decoded
    assign idx = addr[board_pkg::WORD_LSB +: IDX_W];

    // decode, exactly one bank sees req
    assign ram.req = accept && !sel_rom;
    assign rom.req = accept && sel_rom;

    // payload goes to both banks, req picks the one that acts
    assign ram.we    = we;
    assign ram.be    = be;
    assign ram.idx   = idx;
    assign ram.wdata = wdata;

    assign rom.we    = we;
    assign rom.be    = be;
    assign rom.idx   = idx;
    assign rom.wdata = wdata;

    // one ack per accepted request, in the cycle after it
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ack_q     <= 1'b0;
            sel_rom_q <= 1'b0;
        end else begin
            ack_q <= accept;
            if (accept) begin
                sel_rom_q <= sel_rom;
            end
        end
    end

    assign ack = ack_q;

    // banks register their read data on the same edge as ack_q
    always_comb begin
        if (sel_rom_q) begin
            rdata = rom.rdata;
        end else begin
            rdata = ram.rdata;
        end
    end

endmodule

`default_nettype wire

// ==== logic/board_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_top #(
    parameter int unsigned RST_CYCLES = 16,
    parameter int unsigned RAM_WORDS  = 256,
    parameter int unsigned ROM_WORDS  = 256
) (
    input  wire logic              clk,
    input  wire logic              rstn,

    input  wire logic              req,
    input  wire logic              we,
    input  wire board_pkg::addr_t  addr,
    input  wire board_pkg::strb_t  be,
    input  wire board_pkg::data_t  wdata,

    output logic                   ready,
    output logic                   ack,
    output board_pkg::data_t       rdata
);

    // bridge to bank links
    mem_port_if ram_port ();
    mem_port_if rom_port ();

    // hold off requests until the board has settled
    reset_stretch #(
        .RST_CYCLES (RST_CYCLES)
    ) reset_stretch_i (
        .clk   (clk),
        .rstn  (rstn),
        .ready (ready)
    );

    mem_bridge mem_bridge_i (
        .clk   (clk),
        .rstn  (rstn),
        .ready (ready),

        .req   (req),
        .we    (we),
        .addr  (addr),
        .be    (be),
        .wdata (wdata),

        .ack   (ack),
        .rdata (rdata),

        .ram   (ram_port.host),
        .rom   (rom_port.host)
    );

    byte_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) byte_ram_i (
        .clk  (clk),
        .rstn (rstn),
        .port (ram_port.bank)
    );

    instr_rom #(
        .ROM_WORDS (ROM_WORDS)
    ) instr_rom_i (
        .clk  (clk),
        .rstn (rstn),
        .port (rom_port.bank)
    );

endmodule

`default_nettype wire

// ==== include/tb_lfsr.svh ====
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// starting state of the stimulus generator
localparam logic [31:0] TB_LFSR_SEED = 32'h9b80_d074;

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

// one word, one step per bit taken
function automatic logic [31:0] random_word(inout logic [31:0] state);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
        state = lfsr_step(state);
        w     = {w[30:0], state[0]};
    end
    return w;
endfunction

`endif

// ==== sim/board_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_tb;

    `include "tb_lfsr.svh"

    localparam int RST_CYCLES   = 16;
    localparam int RESET_LEN    = 3;
    localparam int READY_MARGIN = 8;

    // what the cycle after an entry should show
    typedef enum logic [1:0] {
        EXP_IDLE,
        EXP_ACK,
        EXP_RAM,
        EXP_ROM
    } exp_sel_t;

    typedef struct packed {
        logic              we;
        board_pkg::addr_t  addr;
        board_pkg::strb_t  be;
        board_pkg::data_t  wdata;
        exp_sel_t          sel;
        logic [2:0]        test;
    } op_t;

    logic              clk = 1'b0;
    logic              rstn;
    logic              req;
    logic              we;
    board_pkg::addr_t  addr;
    board_pkg::strb_t  be;
    board_pkg::data_t  wdata;
    logic              ready;
    logic              ack;
    board_pkg::data_t  rdata;

    op_t               ops[$];
    board_pkg::data_t  ram_model [256];
    logic [31:0]       lfsr;
    int                cycle_count;
    int                cycle_limit = 0;
    int                test_errs [1:6];
    int                total_errors;
    int                tests_run;
    int                tests_failed;

    board_top #(
        .RST_CYCLES (RST_CYCLES)
    ) board_top_i (
        .clk   (clk),
        .rstn  (rstn),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .be    (be),
        .wdata (wdata),
        .ready (ready),
        .ack   (ack),
        .rdata (rdata)
    );

    always #20 clk = ~clk;

    // watchdog, limit is set once the table is known
    initial begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the run did not finish", cycle_count);
        $display("Simulation FAILED");
        $finish;
    end

    // byte b of ROM word i is (i + b) mod 256
    function automatic board_pkg::data_t rom_value(input board_pkg::addr_t a);
        logic [7:0] i;
        i = a[9:2];
        return {i + 8'd3, i + 8'd2, i + 8'd1, i};
    endfunction

    function automatic board_pkg::data_t merge_bytes(input board_pkg::data_t old_w,
                                                     input board_pkg::data_t new_w,
                                                     input board_pkg::strb_t en);
        board_pkg::data_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (en[b]) begin
                w[b*8 +: 8] = new_w[b*8 +: 8];
            end
        end
        return w;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset";
            2:       return "ram word";
            3:       return "byte enables";
            4:       return "rom read";
            5:       return "rom write";
            default: return "back to back";
        endcase
    endfunction

    task automatic add_op(input logic w, input board_pkg::addr_t a, input board_pkg::strb_t en,
                          input exp_sel_t sel, input int test);
        op_t op;
        op.we    = w;
        op.addr  = a;
        op.be    = en;
        op.wdata = '0;
        if (w) begin
            op.wdata = random_word(lfsr);
        end
        op.sel   = sel;
        op.test  = 3'(test);
        ops.push_back(op);
    endtask

    task automatic write_op(input board_pkg::addr_t a, input board_pkg::strb_t en, input int test);
        add_op(1'b1, a, en, EXP_ACK, test);
    endtask

    task automatic read_op(input board_pkg::addr_t a, input int test);
        if (a[board_pkg::BANK_SEL_BIT]) begin
            add_op(1'b0, a, 4'h0, EXP_ROM, test);
        end else begin
            add_op(1'b0, a, 4'h0, EXP_RAM, test);
        end
    endtask

    task automatic idle_op(input int test);
        add_op(1'b0, '0, 4'h0, EXP_IDLE, test);
    endtask

    task automatic build_table();
        // full words, read back after a pause
        write_op(12'h000, 4'hf, 2);
        write_op(12'h004, 4'hf, 2);
        write_op(12'h1a8, 4'hf, 2);
        write_op(12'h3fc, 4'hf, 2);
        idle_op(2);
        read_op(12'h3fc, 2);
        read_op(12'h000, 2);
        read_op(12'h1a8, 2);
        idle_op(2);
        read_op(12'h004, 2);
        // mixed lanes, plus the bit 10 alias and ignored low bits
        write_op(12'h040, 4'hf, 3);
        write_op(12'h040, 4'h5, 3);
        write_op(12'h040, 4'h2, 3);
        read_op(12'h040, 3);
        write_op(12'h440, 4'h8, 3);
        read_op(12'h440, 3);
        read_op(12'h040, 3);
        write_op(12'h044, 4'hf, 3);
        write_op(12'h444, 4'h3, 3);
        read_op(12'h046, 3);
        idle_op(3);
        read_op(12'h800, 4);
        read_op(12'h804, 4);
        read_op(12'hbfc, 4);
        read_op(12'hc10, 4);
        idle_op(4);
        write_op(12'h808, 4'hf, 5);
        read_op(12'h808, 5);
        write_op(12'hc0c, 4'h3, 5);
        idle_op(5);
        read_op(12'h80c, 5);
        idle_op(5);
        // alternating banks, one request per cycle
        read_op(12'h000, 6);
        read_op(12'h800, 6);
        read_op(12'h004, 6);
        read_op(12'h804, 6);
        read_op(12'h040, 6);
        read_op(12'h8fc, 6);
        read_op(12'h1a8, 6);
        read_op(12'hc00, 6);
        read_op(12'h044, 6);
        idle_op(6);
    endtask

    task automatic check_response(input exp_sel_t sel, input board_pkg::data_t exp,
                                  input int test);
        if (sel == EXP_IDLE) begin
            if (ack !== 1'b0) begin
                $display("test %0d: ack seen with no request pending", test);
                test_errs[test]++;
            end
        end else if (ack !== 1'b1) begin
            $display("test %0d: no ack in the cycle after the request", test);
            test_errs[test]++;
        end else if (sel != EXP_ACK && rdata !== exp) begin
            $display("CHECK FAILED rdata: got %h, expected %h (test %0d)", rdata, exp, test);
            test_errs[test]++;
        end
    endtask

    task automatic report_test(input int id);
        tests_run++;
        total_errors += test_errs[id];
        if (test_errs[id] == 0) begin
            $display("test %0d %s: ok", id, test_name(id));
        end else begin
            $display("test %0d %s: %0d errors", id, test_name(id), test_errs[id]);
            tests_failed++;
        end
    endtask

    initial begin
        int                rdy_wait;
        int                pend_test;
        logic              last;
        op_t               op;
        exp_sel_t          pend_sel;
        board_pkg::data_t  pend_data;

        rstn  = 1'b0;
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        be    = '0;
        wdata = '0;
        lfsr  = TB_LFSR_SEED;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        foreach (test_errs[t]) begin
            test_errs[t] = 0;
        end
        build_table();
        cycle_limit = RESET_LEN + RST_CYCLES + READY_MARGIN + ops.size() + 10;

        // requests during reset must be dropped
        repeat (RESET_LEN) begin
            @(negedge clk);
            if (ack !== 1'b0) begin
                $display("test 1: ack raised while rstn is low");
                test_errs[1]++;
            end
            if (ready !== 1'b0) begin
                $display("CHECK FAILED ready: got %h, expected %h (test 1)", ready, 1'b0);
                test_errs[1]++;
            end
            req = ~req;
        end
        rstn     = 1'b1;
        rdy_wait = 0;
        while (ready !== 1'b1 && rdy_wait < RST_CYCLES + READY_MARGIN) begin
            @(negedge clk);
            rdy_wait++;
            if (ack !== 1'b0) begin
                $display("test 1: ack raised before ready");
                test_errs[1]++;
            end
            if (ready !== 1'b1) begin
                req = ~req;
            end else begin
                req = 1'b0;
            end
        end
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("test 1: ack raised for a request issued before ready");
            test_errs[1]++;
        end
        if (ready !== 1'b1) begin
            $display("test 1: ready did not rise within %0d cycles", rdy_wait);
            test_errs[1]++;
        end
        report_test(1);

        if (ready === 1'b1) begin
            pend_sel  = EXP_IDLE;
            pend_data = '0;
            pend_test = 2;
            for (int i = 0; i <= ops.size(); i++) begin
                @(negedge clk);
                if (i > 0) begin
                    check_response(pend_sel, pend_data, pend_test);
                    if (i == ops.size()) begin
                        last = 1'b1;
                    end else begin
                        last = (ops[i].test != ops[i-1].test);
                    end
                    if (last) begin
                        report_test(pend_test);
                    end
                end
                op = '0;
                if (i < ops.size()) begin
                    op = ops[i];
                end
                req       = (op.sel != EXP_IDLE);
                we        = op.we;
                addr      = op.addr;
                be        = op.be;
                wdata     = op.wdata;
                pend_sel  = op.sel;
                pend_test = int'(op.test);
                // model follows the RAM half only
                if (op.sel == EXP_ACK && !op.addr[board_pkg::BANK_SEL_BIT]) begin
                    ram_model[op.addr[9:2]] = merge_bytes(ram_model[op.addr[9:2]],
                                                          op.wdata, op.be);
                end
                if (op.sel == EXP_RAM) begin
                    pend_data = ram_model[op.addr[9:2]];
                end else begin
                    pend_data = rom_value(op.addr);
                end
            end
        end else begin
            $display("tests 2 to 6 not run, the design never became ready");
            tests_failed += 5;
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
logic/board_pkg.sv
logic/mem_port_if.sv
logic/reset_stretch.sv
logic/byte_ram.sv
logic/instr_rom.sv
logic/mem_bridge.sv
logic/board_top.sv
sim/board_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the board testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=board_tb

echo "compiling $TOP"
verilator --binary --timing --timescale 1ns/1ps \
    -f vlog.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "compile failed with status $status"
    exit 1
fi

echo "running $TOP"
"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the result
if grep -q "^Simulation PASSED$" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
